// ==== filelist.f ====
source/cdr_pkg.sv
source/mm_pd.sv
source/phase_err_hold.sv
source/mm_loop_filter.sv
source/loop_snapshot.sv
source/mm_cdr_top.sv
dv/mm_cdr_assertions.sv
dv/mm_cdr_tb.sv

// ==== dv/mm_cdr_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module mm_cdr_tb;

    logic clk;
    logic ext_rstb;
    logic signed [cdr_pkg::nadc-1:0]  din [cdr_pkg::nti-1:0];
    logic signed [cdr_pkg::pd_w-1:0]  pd_offset;
    logic                             ramp_clock;
    logic [cdr_pkg::gain_w-1:0]       kp, ki, kr;
    logic                             en_ramp_est, en_freq_est, en_ext_pi_ctl;
    logic [cdr_pkg::npi-1:0]          ext_pi_ctl;
    logic [cdr_pkg::npi-1:0]          pi_ctl [cdr_pkg::nout-1:0];
    logic                             freq_lvl_cross;
    logic                             sample;
    logic signed [cdr_pkg::pd_w-1:0]  phase_est;
    logic signed [cdr_pkg::est_w-1:0] freq_est;
    logic signed [cdr_pkg::est_w-1:0] ramp_est;

    // Cycle model state
    logic signed [cdr_pkg::nadc-1:0]  m_last;
    logic signed [cdr_pkg::pd_w-1:0]  m_pd, m_err, m_phase_est;
    logic signed [cdr_pkg::est_w-1:0] m_pls, m_neg, m_freq, m_prev, m_phase;
    logic signed [cdr_pkg::est_w-1:0] m_freq_est, m_ramp_est;
    logic                             m_rff, m_rsync, m_flag;
    int                               m_cnt, m_snap;

    int n_checks;
    int n_errors;
    int n_timeouts;

    mm_cdr_top mm_cdr_top_inst (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .din_i            (din),
        .pd_offset_i      (pd_offset),
        .ramp_clock_i     (ramp_clock),
        .kp_i             (kp),
        .ki_i             (ki),
        .kr_i             (kr),
        .en_ramp_est_i    (en_ramp_est),
        .en_freq_est_i    (en_freq_est),
        .en_ext_pi_ctl_i  (en_ext_pi_ctl),
        .ext_pi_ctl_i     (ext_pi_ctl),
        .pi_ctl_o         (pi_ctl),
        .freq_lvl_cross_o (freq_lvl_cross),
        .sample_i         (sample),
        .phase_est_o      (phase_est),
        .freq_est_o       (freq_est),
        .ramp_est_o       (ramp_est)
    );

    always #10 clk = ~clk;

    // Saturated Mueller-Muller error of the applied samples plus the offset
    function automatic logic signed [cdr_pkg::pd_w-1:0] detector_error();
        int sum, cur, prev;
        sum  = pd_offset;
        prev = m_last;
        for (int k = 0; k < cdr_pkg::nti; k++) begin
            cur  = din[k];
            sum  = sum + ((prev < 0) ? -cur : cur) - ((cur < 0) ? -prev : prev);
            prev = cur;
        end
        if (sum > 511) sum = 511;
        if (sum < -512) sum = -512;
        return sum;
    endfunction

    function automatic logic signed [cdr_pkg::est_w-1:0] scaled_err(
        input logic signed [cdr_pkg::pd_w-1:0] e,
        input logic [cdr_pkg::gain_w-1:0] sh
    );
        logic signed [cdr_pkg::est_w-1:0] w;
        w = e;
        return w <<< sh;
    endfunction

    function automatic logic [cdr_pkg::npi-1:0] pi_code();
        logic signed [cdr_pkg::est_w-1:0] p;
        p = m_phase;
        if (en_ext_pi_ctl) return ext_pi_ctl;
        return p[cdr_pkg::est_w-1 -: cdr_pkg::npi];
    endfunction

    // Advances the model by one clock edge from the applied inputs
    task automatic advance_model();
        logic signed [cdr_pkg::est_w-1:0] upd, pls_n, neg_n, sel;
        upd   = m_freq + scaled_err(m_err, ki) + (m_rsync ? m_pls : m_neg);
        pls_n = !en_ramp_est ? '0 : (m_rsync ? m_pls + scaled_err(m_err, kr) : m_pls);
        neg_n = !en_ramp_est ? '0 : (!m_rsync ? m_neg + scaled_err(m_err, kr) : m_neg);
        sel   = m_rsync ? pls_n : neg_n;
        if (m_snap == 2) begin
            m_phase_est = m_phase[cdr_pkg::est_w-1 -: cdr_pkg::pd_w];
            m_freq_est  = upd;
            m_ramp_est  = sel;
            m_snap      = 0;
        end else if (m_snap == 0 && !sample) begin
            m_snap = 1;
        end else if (m_snap == 1 && sample) begin
            m_snap = 2;
        end
        m_flag  = upd > m_prev;
        m_prev  = upd;
        m_phase = m_phase + scaled_err(m_err, kp) + m_freq;
        m_freq  = en_freq_est ? upd : '0;
        m_pls   = pls_n;
        m_neg   = neg_n;
        m_rsync = m_rff;
        m_rff   = ramp_clock;
        m_err   = (m_cnt == cdr_pkg::hold_cycles) ? m_pd : '0;
        if (m_cnt < cdr_pkg::hold_cycles) m_cnt++;
        m_pd    = detector_error();
        m_last  = din[cdr_pkg::nti-1];
    endtask

    task automatic compare_pi(input logic [cdr_pkg::npi-1:0] got,
                              input logic [cdr_pkg::npi-1:0] exp, input string name);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_est(input logic signed [cdr_pkg::est_w-1:0] got,
                               input logic signed [cdr_pkg::est_w-1:0] exp, input string name);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_phase(input logic signed [cdr_pkg::pd_w-1:0] got,
                                 input logic signed [cdr_pkg::pd_w-1:0] exp, input string name);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
        end
    endtask

    task automatic compare_bit(input logic got, input logic exp, input string name);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("error t=%0t %s got=%0b exp=%0b", $time, name, got, exp);
        end
    endtask

    // Every output checked at the falling edge after one clock edge
    task automatic step();
        advance_model();
        @(posedge clk);
        @(negedge clk);
        for (int k = 0; k < cdr_pkg::nout; k++) begin
            compare_pi(pi_ctl[k], pi_code(), $sformatf("pi_ctl_o[%0d]", k));
        end
        compare_bit(freq_lvl_cross, m_flag, "freq_lvl_cross_o");
        compare_phase(phase_est, m_phase_est, "phase_est_o");
        compare_est(freq_est, m_freq_est, "freq_est_o");
        compare_est(ramp_est, m_ramp_est, "ramp_est_o");
    endtask

    task automatic random_samples();
        for (int k = 0; k < cdr_pkg::nti; k++) din[k] = $urandom;
    endtask

    task automatic hold_after_reset();
        en_freq_est = 1'b1;
        en_ramp_est = 1'b1;
        for (int n = 0; n < cdr_pkg::hold_cycles + 12; n++) begin
            random_samples();
            sample = (n % 4) >= 2;   // Snapshot every four cycles
            step();
        end
        sample = 1'b0;
    endtask

    task automatic override_pi_code();
        en_ext_pi_ctl = 1'b1;
        for (int n = 0; n < 10; n++) begin
            ext_pi_ctl = $urandom;
            random_samples();
            step();
        end
        en_ext_pi_ctl = 1'b0;
        repeat (3) step();
    endtask

    task automatic proportional_path();
        en_freq_est = 1'b0;
        en_ramp_est = 1'b0;
        kp          = 3'd2;
        pd_offset   = 10'sd7;
        for (int k = 0; k < cdr_pkg::nti; k++) din[k] = '0;
        for (int n = 0; n < 12; n++) begin
            sample = n[1];
            step();
        end
        // Alternating extremes push the detector sum past both rails
        for (int n = 0; n < 12; n++) begin
            pd_offset = (n < 6) ? 10'sh1ff : 10'sh200;
            sample    = n[1];
            for (int k = 0; k < cdr_pkg::nti; k++) begin
                din[k] = ((n + k) % 2) ? 8'sh7f : 8'sh80;
            end
            step();
        end
        sample    = 1'b0;
        pd_offset = '0;
    endtask

    task automatic integral_path();
        en_freq_est = 1'b1;
        kp          = 3'd1;
        ki          = 3'd0;
        for (int n = 0; n < 24; n++) begin
            random_samples();
            sample = n[1];
            step();
        end
        sample = 1'b0;
    endtask

    task automatic ramp_estimators();
        en_ramp_est = 1'b1;
        kr          = 3'd1;
        for (int n = 0; n < 40; n++) begin
            if (n % 5 == 0) ramp_clock = ~ramp_clock;
            random_samples();
            sample = n[1];
            step();
        end
        en_ramp_est = 1'b0;
        sample      = 1'b0;
        repeat (4) step();
        sample = 1'b1;
        repeat (4) step();
        sample     = 1'b0;
        ramp_clock = ~ramp_clock;   // Selects the other cleared estimator
        repeat (4) step();
        sample = 1'b1;
        repeat (4) step();
        sample = 1'b0;
        step();
    endtask

    // Counts edges from the rise of sample_i until the snapshot moves
    task automatic capture_latency(output int edges);
        logic signed [cdr_pkg::est_w-1:0] old;
        old    = freq_est;
        edges  = 0;
        sample = 1'b1;
        while (freq_est === old && edges < 8) begin
            step();
            edges++;
        end
        if (freq_est === old) begin
            n_timeouts++;
            edges = -1;
            $display("timeout: snapshot never captured after sample_i rose at %0t", $time);
        end
    endtask

    task automatic snapshot_protocol();
        int edges;
        en_freq_est = 1'b1;
        pd_offset   = 10'sd5;                  // Steady error keeps the frequency rising
        for (int k = 0; k < cdr_pkg::nti; k++) din[k] = '0;
        sample = 1'b0;
        repeat (3) step();
        capture_latency(edges);
        if (edges >= 0 && edges != 2) begin
            n_errors++;
            $display("snapshot captured %0d edges after the rise instead of 2", edges);
        end
        repeat (6) step();                     // No second capture while held high
        sample = 1'b0;
        step();
        capture_latency(edges);
        if (edges >= 0 && edges != 2) begin
            n_errors++;
            $display("second snapshot captured %0d edges after the rise instead of 2", edges);
        end
        sample = 1'b0;
        step();
    endtask

    initial begin
        void'($urandom(40));
        clk = 1'b0;
        ext_rstb = 1'b0;
        for (int k = 0; k < cdr_pkg::nti; k++) din[k] = '0;
        pd_offset = '0;
        ramp_clock = 1'b0;
        kp = 3'd1;
        ki = 3'd0;
        kr = 3'd0;
        en_ramp_est = 1'b0;
        en_freq_est = 1'b0;
        en_ext_pi_ctl = 1'b0;
        ext_pi_ctl = '0;
        sample = 1'b0;
        m_last = '0;
        m_pd = '0;
        m_err = '0;
        m_phase_est = '0;
        m_pls = '0;
        m_neg = '0;
        m_freq = '0;
        m_prev = '0;
        m_phase = '0;
        m_freq_est = '0;
        m_ramp_est = '0;
        m_rff = 1'b0;
        m_rsync = 1'b0;
        m_flag = 1'b0;
        m_cnt = 0;
        m_snap = 0;
        n_checks = 0;
        n_errors = 0;
        n_timeouts = 0;
        repeat (8) @(negedge clk);
        ext_rstb = 1'b1;

        hold_after_reset();
        override_pi_code();
        proportional_path();
        integral_path();
        ramp_estimators();
        snapshot_protocol();

        $display("checks=%0d errors=%0d timeouts=%0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/mm_cdr_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module mm_cdr_assertions (
    input wire logic                              clk,
    input wire logic                              ext_rstb,
    input wire logic [cdr_pkg::npi-1:0]           pi_ctl_o [cdr_pkg::nout-1:0],
    input wire logic                              en_ext_pi_ctl_i,
    input wire logic [cdr_pkg::npi-1:0]           ext_pi_ctl_i,
    input wire logic                              freq_lvl_cross_o,
    input wire logic signed [cdr_pkg::pd_w-1:0]   phase_est_o,
    input wire logic signed [cdr_pkg::est_w-1:0]  freq_est_o,
    input wire logic signed [cdr_pkg::est_w-1:0]  ramp_est_o,
    input wire logic [1:0]                        snap_state,
    input wire logic                              hold_released
);

    // Every interpolator lane carries one code
    lanes_equal: assert property (@(posedge clk) disable iff (!ext_rstb)
        (pi_ctl_o[1] == pi_ctl_o[0]) && (pi_ctl_o[2] == pi_ctl_o[0])
        && (pi_ctl_o[3] == pi_ctl_o[0]))
        else $error("interpolator lanes differ");

    override_code: assert property (@(posedge clk) disable iff (!ext_rstb)
        en_ext_pi_ctl_i |-> (pi_ctl_o[0] == ext_pi_ctl_i))
        else $error("override code not on the interpolator lanes");

    snapshot_stable: assert property (@(posedge clk) disable iff (!ext_rstb)
        (snap_state != cdr_pkg::snap_sample) |=>
        ($stable(phase_est_o) && $stable(freq_est_o) && $stable(ramp_est_o)))
        else $error("snapshot outputs changed without a capture");

    flag_quiet_in_hold: assert property (@(posedge clk) disable iff (!ext_rstb)
        !hold_released |-> !freq_lvl_cross_o)
        else $error("level crossing flag set during the hold period");

endmodule

bind mm_cdr_top mm_cdr_assertions mm_cdr_assertions_inst (
    .clk              (clk),
    .ext_rstb         (ext_rstb),
    .pi_ctl_o         (pi_ctl_o),
    .en_ext_pi_ctl_i  (en_ext_pi_ctl_i),
    .ext_pi_ctl_i     (ext_pi_ctl_i),
    .freq_lvl_cross_o (freq_lvl_cross_o),
    .phase_est_o      (phase_est_o),
    .freq_est_o       (freq_est_o),
    .ramp_est_o       (ramp_est_o),
    .snap_state       (loop_snapshot_inst.state),
    .hold_released    (phase_err_hold_inst.released)
);

`default_nettype wire

// ==== source/mm_cdr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mm_cdr_top (
    input  wire logic                              clk,
    input  wire logic                              ext_rstb,

    // ADC samples and detector trim
    input  wire logic signed [cdr_pkg::nadc-1:0]   din_i [cdr_pkg::nti-1:0],
    input  wire logic signed [cdr_pkg::pd_w-1:0]   pd_offset_i,

    // Loop control
    input  wire logic                              ramp_clock_i,
    input  wire logic [cdr_pkg::gain_w-1:0]        kp_i,
    input  wire logic [cdr_pkg::gain_w-1:0]        ki_i,
    input  wire logic [cdr_pkg::gain_w-1:0]        kr_i,
    input  wire logic                              en_ramp_est_i,
    input  wire logic                              en_freq_est_i,
    input  wire logic                              en_ext_pi_ctl_i,
    input  wire logic [cdr_pkg::npi-1:0]           ext_pi_ctl_i,

    // Interpolator side
    output logic [cdr_pkg::npi-1:0]                pi_ctl_o [cdr_pkg::nout-1:0],
    output logic                                   freq_lvl_cross_o,

    // Debug snapshot
    input  wire logic                              sample_i,
    output logic signed [cdr_pkg::pd_w-1:0]        phase_est_o,
    output logic signed [cdr_pkg::est_w-1:0]       freq_est_o,
    output logic signed [cdr_pkg::est_w-1:0]       ramp_est_o
);

    logic signed [cdr_pkg::pd_w-1:0]  pd_err;
    logic signed [cdr_pkg::pd_w-1:0]  err;
    logic signed [cdr_pkg::pd_w-1:0]  phase_out;
    logic signed [cdr_pkg::est_w-1:0] freq_upd;
    logic signed [cdr_pkg::est_w-1:0] ramp_sel_upd;

    mm_pd mm_pd_inst (
        .clk         (clk),
        .ext_rstb    (ext_rstb),
        .din_i       (din_i),
        .pd_offset_i (pd_offset_i),
        .pd_err_o    (pd_err)
    );

    // Keeps the loop quiet while the front end settles
    phase_err_hold phase_err_hold_inst (
        .clk      (clk),
        .ext_rstb (ext_rstb),
        .pd_err_i (pd_err),
        .err_o    (err)
    );

    mm_loop_filter mm_loop_filter_inst (
        .clk              (clk),
        .ext_rstb         (ext_rstb),
        .err_i            (err),
        .ramp_clock_i     (ramp_clock_i),
        .kp_i             (kp_i),
        .ki_i             (ki_i),
        .kr_i             (kr_i),
        .en_ramp_est_i    (en_ramp_est_i),
        .en_freq_est_i    (en_freq_est_i),
        .en_ext_pi_ctl_i  (en_ext_pi_ctl_i),
        .ext_pi_ctl_i     (ext_pi_ctl_i),
        .pi_ctl_o         (pi_ctl_o),
        .freq_lvl_cross_o (freq_lvl_cross_o),
        .phase_out_o      (phase_out),
        .freq_upd_o       (freq_upd),
        .ramp_sel_upd_o   (ramp_sel_upd)
    );

    loop_snapshot loop_snapshot_inst (
        .clk            (clk),
        .ext_rstb       (ext_rstb),
        .sample_i       (sample_i),
        .phase_out_i    (phase_out),
        .freq_upd_i     (freq_upd),
        .ramp_sel_upd_i (ramp_sel_upd),
        .phase_est_o    (phase_est_o),
        .freq_est_o     (freq_est_o),
        .ramp_est_o     (ramp_est_o)
    );

endmodule

`default_nettype wire

// ==== source/loop_snapshot.sv ====
`timescale 1ns/1ps
`default_nettype none

module loop_snapshot (
    input  wire logic                              clk,
    input  wire logic                              ext_rstb,
    input  wire logic                              sample_i,
    input  wire logic signed [cdr_pkg::pd_w-1:0]   phase_out_i,
    input  wire logic signed [cdr_pkg::est_w-1:0]  freq_upd_i,
    input  wire logic signed [cdr_pkg::est_w-1:0]  ramp_sel_upd_i,
    output logic signed [cdr_pkg::pd_w-1:0]        phase_est_o,
    output logic signed [cdr_pkg::est_w-1:0]      freq_est_o,
    output logic signed [cdr_pkg::est_w-1:0]      ramp_est_o
);

    cdr_pkg::snap_state_t state;
    cdr_pkg::snap_state_t state_nxt;

    // A capture needs sample_i low first, so a held request fires once
    always_comb begin
        state_nxt = state;
        case (state)
            cdr_pkg::snap_wait: begin
                if (!sample_i) begin
                    state_nxt = cdr_pkg::snap_ready;
                end
            end
            cdr_pkg::snap_ready: begin
                if (sample_i) begin
                    state_nxt = cdr_pkg::snap_sample;
                end
            end
            cdr_pkg::snap_sample: state_nxt = cdr_pkg::snap_wait;
            default:              state_nxt = cdr_pkg::snap_wait;
        endcase
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            state <= cdr_pkg::snap_wait;
        end else begin
            state <= state_nxt;
        end
    end

    // Outputs hold between captures
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            phase_est_o <= '0;
            freq_est_o  <= '0;
            ramp_est_o  <= '0;
        end else if (state == cdr_pkg::snap_sample) begin
            phase_est_o <= phase_out_i;
            freq_est_o  <= freq_upd_i;
            ramp_est_o  <= ramp_sel_upd_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/mm_loop_filter.sv ====
`timescale 1ns/1ps
`default_nettype none

module mm_loop_filter (
    input  wire logic                              clk,
    input  wire logic                              ext_rstb,
    input  wire logic signed [cdr_pkg::pd_w-1:0]   err_i,
    input  wire logic                              ramp_clock_i,
    input  wire logic [cdr_pkg::gain_w-1:0]        kp_i,
    input  wire logic [cdr_pkg::gain_w-1:0]        ki_i,
    input  wire logic [cdr_pkg::gain_w-1:0]        kr_i,
    input  wire logic                              en_ramp_est_i,
    input  wire logic                              en_freq_est_i,
    input  wire logic                              en_ext_pi_ctl_i,
    input  wire logic [cdr_pkg::npi-1:0]           ext_pi_ctl_i,
    output logic [cdr_pkg::npi-1:0]                pi_ctl_o [cdr_pkg::nout-1:0],
    output logic                                   freq_lvl_cross_o,
    output logic signed [cdr_pkg::pd_w-1:0]        phase_out_o,
    output logic signed [cdr_pkg::est_w-1:0]       freq_upd_o,
    output logic signed [cdr_pkg::est_w-1:0]       ramp_sel_upd_o
);

    // Ramp clock is asynchronous to clk
    logic ramp_ff;
    logic ramp_sync;

    logic signed [cdr_pkg::est_w-1:0] err_ext;
    logic signed [cdr_pkg::est_w-1:0] err_kp;
    logic signed [cdr_pkg::est_w-1:0] err_ki;
    logic signed [cdr_pkg::est_w-1:0] err_kr;

    logic signed [cdr_pkg::est_w-1:0] ramp_pls_q;
    logic signed [cdr_pkg::est_w-1:0] ramp_neg_q;
    logic signed [cdr_pkg::est_w-1:0] ramp_pls_d;
    logic signed [cdr_pkg::est_w-1:0] ramp_neg_d;

    logic signed [cdr_pkg::est_w-1:0] freq_q;
    logic signed [cdr_pkg::est_w-1:0] freq_d;
    logic signed [cdr_pkg::est_w-1:0] freq_upd;
    logic signed [cdr_pkg::est_w-1:0] prev_freq_upd_q;

    logic signed [cdr_pkg::est_w-1:0] phase_q;
    logic signed [cdr_pkg::est_w-1:0] phase_d;

    logic [cdr_pkg::npi-1:0] loop_code;

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            ramp_ff   <= 1'b0;
            ramp_sync <= 1'b0;
        end else begin
            ramp_ff   <= ramp_clock_i;
            ramp_sync <= ramp_ff;
        end
    end

    // Error widened to the accumulator width before any shift
    assign err_ext = {{cdr_pkg::phase_shift{err_i[cdr_pkg::pd_w-1]}}, err_i};
    assign err_kp  = err_ext <<< kp_i;
    assign err_ki  = err_ext <<< ki_i;
    assign err_kr  = err_ext <<< kr_i;

    // Ramp estimators, one per half of the ramp clock
    always_comb begin
        ramp_pls_d = ramp_pls_q;
        ramp_neg_d = ramp_neg_q;
        if (!en_ramp_est_i) begin
            ramp_pls_d = '0;
            ramp_neg_d = '0;
        end else if (ramp_sync) begin
            ramp_pls_d = ramp_pls_q + err_kr;
        end else begin
            ramp_neg_d = ramp_neg_q + err_kr;
        end
    end

    assign ramp_sel_upd_o = ramp_sync ? ramp_pls_d : ramp_neg_d;

    // Frequency path, all sums wrap in est_w bits
    assign freq_upd = freq_q + err_ki + (ramp_sync ? ramp_pls_q : ramp_neg_q);
    assign freq_d   = en_freq_est_i ? freq_upd : '0;

    assign phase_d = phase_q + err_kp + freq_q;   // Uses the old frequency estimate

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            ramp_pls_q      <= '0;
            ramp_neg_q      <= '0;
            freq_q          <= '0;
            prev_freq_upd_q <= '0;
            phase_q         <= '0;
        end else begin
            ramp_pls_q      <= ramp_pls_d;
            ramp_neg_q      <= ramp_neg_d;
            freq_q          <= freq_d;
            prev_freq_upd_q <= freq_upd;
            phase_q         <= phase_d;
        end
    end

    // Rising frequency flag
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            freq_lvl_cross_o <= 1'b0;
        end else begin
            freq_lvl_cross_o <= (freq_upd > prev_freq_upd_q);
        end
    end

    assign freq_upd_o  = freq_upd;
    assign phase_out_o = phase_q[cdr_pkg::est_w-1 -: cdr_pkg::pd_w];   // Drop fraction bits
    assign loop_code   = phase_out_o[cdr_pkg::pd_w-1 -: cdr_pkg::npi];

    // Same code on every interpolator lane
    always_comb begin
        for (int k = 0; k < cdr_pkg::nout; k++) begin
            pi_ctl_o[k] = en_ext_pi_ctl_i ? ext_pi_ctl_i : loop_code;
        end
    end

endmodule

`default_nettype wire

// ==== source/phase_err_hold.sv ====
`timescale 1ns/1ps
`default_nettype none

module phase_err_hold (
    input  wire logic                            clk,
    input  wire logic                            ext_rstb,
    input  wire logic signed [cdr_pkg::pd_w-1:0] pd_err_i,
    output logic signed [cdr_pkg::pd_w-1:0]      err_o
);

    logic [cdr_pkg::hold_cnt_w-1:0] hold_cnt;
    logic                           released;

    // Counter parks at hold_cycles and stays there until the next reset
    assign released = (hold_cnt == cdr_pkg::hold_cnt_w'(cdr_pkg::hold_cycles));

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            hold_cnt <= '0;
        end else if (!released) begin
            hold_cnt <= hold_cnt + 1'b1;
        end
    end

    // Zero for the first hold_cycles edges, then follow the detector
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            err_o <= '0;
        end else begin
            err_o <= released ? pd_err_i : '0;
        end
    end

endmodule

`default_nettype wire

// ==== source/mm_pd.sv ====
`timescale 1ns/1ps
`default_nettype none

module mm_pd (
    input  wire logic                              clk,
    input  wire logic                              ext_rstb,
    input  wire logic signed [cdr_pkg::nadc-1:0]   din_i [cdr_pkg::nti-1:0],
    input  wire logic signed [cdr_pkg::pd_w-1:0]   pd_offset_i,
    output logic signed [cdr_pkg::pd_w-1:0]        pd_err_o
);

    localparam int term_w = cdr_pkg::nadc + 2;

    localparam logic signed [cdr_pkg::pd_sum_w-1:0] sat_max = (1 <<< (cdr_pkg::pd_w - 1)) - 1;
    localparam logic signed [cdr_pkg::pd_sum_w-1:0] sat_min = -(1 <<< (cdr_pkg::pd_w - 1));

    logic signed [cdr_pkg::nadc-1:0]     last_q;      // Last sample of the previous cycle
    logic signed [cdr_pkg::nadc-1:0]     chain [cdr_pkg::nti:0];
    logic signed [cdr_pkg::pd_sum_w-1:0] err_sum;
    logic signed [cdr_pkg::pd_w-1:0]     err_sat;

    // sign(prev)*cur - sign(cur)*prev, zero counts as positive
    function automatic logic signed [term_w-1:0] lane_term(
        input logic signed [cdr_pkg::nadc-1:0] cur,
        input logic signed [cdr_pkg::nadc-1:0] prev
    );
        logic signed [term_w-1:0] cur_x;
        logic signed [term_w-1:0] prev_x;
        cur_x     = cur;
        prev_x    = prev;
        lane_term = (prev[cdr_pkg::nadc-1] ? -cur_x : cur_x)
                  - (cur[cdr_pkg::nadc-1] ? -prev_x : prev_x);
    endfunction

    // Sample chain with the carried sample in front
    always_comb begin
        chain[0] = last_q;
        for (int k = 0; k < cdr_pkg::nti; k++) begin
            chain[k+1] = din_i[k];
        end
    end

    always_comb begin
        err_sum = pd_offset_i;
        for (int k = 0; k < cdr_pkg::nti; k++) begin
            err_sum = err_sum + lane_term(chain[k+1], chain[k]);
        end
    end

    always_comb begin
        if (err_sum > sat_max) begin
            err_sat = sat_max[cdr_pkg::pd_w-1:0];
        end else if (err_sum < sat_min) begin
            err_sat = sat_min[cdr_pkg::pd_w-1:0];
        end else begin
            err_sat = err_sum[cdr_pkg::pd_w-1:0];
        end
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            last_q   <= '0;
            pd_err_o <= '0;
        end else begin
            last_q   <= din_i[cdr_pkg::nti-1];
            pd_err_o <= err_sat;
        end
    end

endmodule

`default_nettype wire

// ==== source/cdr_pkg.sv ====
`default_nettype none

package cdr_pkg;

    // ADC side
    localparam int nadc = 8;            // Sample width, signed
    localparam int nti  = 4;            // Interleaved samples per clock

    // Phase interpolator side
    localparam int npi  = 8;            // Code width
    localparam int nout = 4;            // Number of interpolator lanes

    // Phase detector error, two bits of growth over a sample
    localparam int pd_w = nadc + 2;

    // Lane sums before saturation, room for nti terms plus the offset
    localparam int pd_sum_w = pd_w + 3;

    // Loop filter accumulators carry phase_shift fractional bits
    localparam int phase_shift = 8;
    localparam int est_w       = pd_w + phase_shift;

    // Shift amount for kp, ki and kr
    localparam int gain_w = 3;

    // Start-up hold of the phase error
    localparam int hold_cycles = 32;
    localparam int hold_cnt_w  = $clog2(hold_cycles + 1);

    // Debug snapshot FSM
    typedef enum logic [1:0] {
        snap_wait   = 2'd0,   // Waits for sample_i low
        snap_ready  = 2'd1,   // Armed, waits for sample_i high
        snap_sample = 2'd2    // Captures on the next edge
    } snap_state_t;

endpackage

`default_nettype wire
